/* common/switch_pkg.sv */
package switch_pkg;

    // header geometry, byte i of a header sits at bits [8*i +: 8]
    localparam int HDR_LEN   = 16;
    localparam int TAG_OFF   = 0;
    localparam int KEY_OFF   = 2;
    localparam int KEY_BYTES = 2;

    localparam int NUM_PORTS  = 4;
    localparam int PARSE_SIZE = 4;

    // controller port
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // top two address bits pick the region
    localparam logic [1:0] REGION_PARSE  = 2'd0;
    localparam logic [1:0] REGION_MATCH  = 2'd1;
    localparam logic [1:0] REGION_ACTION = 2'd2;
    localparam logic [1:0] REGION_MISS   = 2'd3;

    typedef logic [HDR_LEN*8-1:0]   hdr_t;
    typedef logic [3:0]             hdr_id_t;
    typedef logic [KEY_BYTES*8-1:0] key_t;
    typedef logic [NUM_PORTS-1:0]   port_mask_t;

    typedef enum logic [1:0] {
        OP_FORWARD = 2'd0,
        OP_REWRITE = 2'd1,
        OP_DROP    = 2'd2
    } op_e;

    typedef struct packed {
        logic        valid;
        logic [18:0] rsvd;
        logic [7:0]  tag;
        hdr_id_t     hdr_id;
    } parse_entry_t;

    typedef struct packed {
        logic        valid;
        logic [10:0] rsvd;
        hdr_id_t     hdr_id;
        key_t        key;
    } match_entry_t;

    typedef struct packed {
        op_e         op;
        logic [13:0] rsvd;
        port_mask_t  port;
        logic [3:0]  byte_idx;
        logic [7:0]  byte_val;
    } action_t;

    // one controller word, meaning depends on region
    typedef union packed {
        parse_entry_t        parse;
        match_entry_t        flow;
        action_t             act;
        logic [DATA_W-1:0]   raw;
    } table_word_u;

endpackage

/* hdl/flow_table.sv */
`timescale 1ns/1ps

module flow_table #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          ctrl_mem_ce_i,
    input  logic                          ctrl_mem_we_i,
    input  logic [switch_pkg::ADDR_W-1:0] ctrl_mem_addr_i,
    input  logic [switch_pkg::DATA_W-1:0] ctrl_mem_data_i,
    output logic [switch_pkg::DATA_W-1:0] ctrl_mem_data_o,
    output logic                          ctrl_mem_ready_o,
    output switch_pkg::parse_entry_t      parse_tab_o [switch_pkg::PARSE_SIZE],
    output switch_pkg::match_entry_t      match_tab_o [NUM_ENTRIES],
    output switch_pkg::action_t           action_tab_o [NUM_ENTRIES],
    output switch_pkg::action_t           miss_action_o
);
    import switch_pkg::*;

    localparam int IDX_W  = ADDR_W - 2;
    localparam int PIDX_W = $clog2(PARSE_SIZE);
    localparam int EIDX_W = $clog2(NUM_ENTRIES);

    logic [1:0]       region;
    logic [IDX_W-1:0] idx;
    logic             parse_ok;
    logic             entry_ok;
    logic             miss_ok;
    table_word_u      wr_word;
    table_word_u      rd_word;

    assign region   = ctrl_mem_addr_i[ADDR_W-1 -: 2];
    assign idx      = ctrl_mem_addr_i[IDX_W-1:0];
    assign parse_ok = idx < IDX_W'(PARSE_SIZE);
    assign entry_ok = idx < IDX_W'(NUM_ENTRIES);
    // miss region holds a single word at index 0
    assign miss_ok  = idx == '0;
    assign wr_word  = ctrl_mem_data_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PARSE_SIZE; i++) begin
                parse_tab_o[i] <= '0;
            end
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                match_tab_o[i]  <= '0;
                action_tab_o[i] <= '0;
            end
            miss_action_o <= '0;
        end else if (ctrl_mem_ce_i && ctrl_mem_we_i) begin
            case (region)
                REGION_PARSE: if (parse_ok) parse_tab_o[idx[PIDX_W-1:0]] <= wr_word.parse;
                REGION_MATCH: if (entry_ok) match_tab_o[idx[EIDX_W-1:0]] <= wr_word.flow;
                REGION_ACTION: if (entry_ok) action_tab_o[idx[EIDX_W-1:0]] <= wr_word.act;
                default: if (miss_ok) miss_action_o <= wr_word.act;
            endcase
        end
    end

    // readback, unmapped indices give zero
    always_comb begin
        rd_word = '0;
        case (region)
            REGION_PARSE: if (parse_ok) rd_word.parse = parse_tab_o[idx[PIDX_W-1:0]];
            REGION_MATCH: if (entry_ok) rd_word.flow = match_tab_o[idx[EIDX_W-1:0]];
            REGION_ACTION: if (entry_ok) rd_word.act = action_tab_o[idx[EIDX_W-1:0]];
            default: if (miss_ok) rd_word.act = miss_action_o;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl_mem_ready_o <= 1'b0;
        end else begin
            ctrl_mem_ready_o <= ctrl_mem_ce_i;
        end
    end

    always_ff @(posedge clk) begin
        ctrl_mem_data_o <= (ctrl_mem_ce_i && !ctrl_mem_we_i) ? rd_word.raw : '0;
    end

    a_ready_after_ce: assert property (
        @(posedge clk) disable iff (reset_i)
        $rose(ctrl_mem_ready_o) |-> $past(ctrl_mem_ce_i)
    );

endmodule

/* pipeline/hdr_parser.sv */
`timescale 1ns/1ps

module hdr_parser (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     pkt_valid_i,
    input  switch_pkg::hdr_t         pkt_hdr_i,
    input  switch_pkg::parse_entry_t parse_tab_i [switch_pkg::PARSE_SIZE],
    output logic                     ps_valid_o,
    output switch_pkg::hdr_t         ps_hdr_o,
    output switch_pkg::hdr_id_t      ps_hdr_id_o
);
    import switch_pkg::*;

    logic [7:0] tag;
    hdr_id_t    hdr_id;

    assign tag = pkt_hdr_i[TAG_OFF*8 +: 8];

    always_comb begin
        hdr_id = '0;
        // walk downwards so the lowest matching index is left standing
        for (int i = PARSE_SIZE - 1; i >= 0; i--) begin
            if (parse_tab_i[i].valid && parse_tab_i[i].tag == tag) begin
                hdr_id = parse_tab_i[i].hdr_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ps_valid_o <= 1'b0;
        end else begin
            ps_valid_o <= pkt_valid_i;
        end
    end

    // header travels on from here to the executor
    always_ff @(posedge clk) begin
        if (pkt_valid_i) begin
            ps_hdr_o    <= pkt_hdr_i;
            ps_hdr_id_o <= hdr_id;
        end
    end

endmodule

/* pipeline/key_matcher.sv */
`timescale 1ns/1ps

module key_matcher #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     pkt_valid_i,
    input  switch_pkg::hdr_t         pkt_hdr_i,
    input  switch_pkg::match_entry_t match_tab_i [NUM_ENTRIES],
    output logic [NUM_ENTRIES-1:0]   mt_hits_o,
    output switch_pkg::hdr_id_t      mt_hdr_ids_o [NUM_ENTRIES]
);
    import switch_pkg::*;

    key_t                   key;
    logic [NUM_ENTRIES-1:0] hits;

    assign key = pkt_hdr_i[KEY_OFF*8 +: KEY_BYTES*8];

    // one comparator per flow entry
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            hits[i] = match_tab_i[i].valid && (match_tab_i[i].key == key);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mt_hits_o <= '0;
        end else begin
            mt_hits_o <= pkt_valid_i ? hits : '0;
        end
    end

    // class check happens one stage later against the parser result
    always_ff @(posedge clk) begin
        if (pkt_valid_i) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                mt_hdr_ids_o[i] <= match_tab_i[i].hdr_id;
            end
        end
    end

endmodule

/* pipeline/action_executor.sv */
`timescale 1ns/1ps

module action_executor #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   ps_valid_i,
    input  switch_pkg::hdr_t       ps_hdr_i,
    input  switch_pkg::hdr_id_t    ps_hdr_id_i,
    input  logic [NUM_ENTRIES-1:0] mt_hits_i,
    input  switch_pkg::hdr_id_t    mt_hdr_ids_i [NUM_ENTRIES],
    input  switch_pkg::action_t    action_tab_i [NUM_ENTRIES],
    input  switch_pkg::action_t    miss_action_i,
    output logic                   ex_wr_o,
    output switch_pkg::hdr_t       ex_hdr_o,
    output switch_pkg::port_mask_t ex_port_o
);
    import switch_pkg::*;

    action_t                act_tab_q [NUM_ENTRIES];
    action_t                miss_q;
    logic [NUM_ENTRIES-1:0] qual_hits;
    logic                   hit;
    action_t                act;
    hdr_t                   hdr_new;
    logic                   drop;

    // actions as they stood when stage 1 sampled the packet
    always_ff @(posedge clk) begin
        act_tab_q <= action_tab_i;
        miss_q    <= miss_action_i;
    end

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            qual_hits[i] = mt_hits_i[i] && (mt_hdr_ids_i[i] == ps_hdr_id_i);
        end
    end

    // lowest hitting index wins, else miss action
    always_comb begin
        hit = 1'b0;
        act = miss_q;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (qual_hits[i]) begin
                hit = 1'b1;
                act = act_tab_q[i];
            end
        end
    end

    always_comb begin
        hdr_new = ps_hdr_i;
        drop    = 1'b0;
        case (act.op)
            OP_FORWARD: drop = 1'b0;
            OP_REWRITE: hdr_new[act.byte_idx*8 +: 8] = act.byte_val;
            default: drop = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_wr_o <= 1'b0;
        end else begin
            ex_wr_o <= ps_valid_i && !drop;
        end
    end

    always_ff @(posedge clk) begin
        if (ps_valid_i) begin
            ex_hdr_o  <= hdr_new;
            ex_port_o <= act.port;
        end
    end

    a_hit_has_port: assert property (
        @(posedge clk) disable iff (reset_i)
        ex_wr_o && $past(hit) |-> ex_port_o != '0
    );

endmodule

/* hdl/pkt_latch.sv */
`timescale 1ns/1ps

module pkt_latch (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   wr_i,
    input  switch_pkg::hdr_t       pkt_hdr_i,
    input  switch_pkg::port_mask_t out_port_i,
    input  logic                   rd_i,
    output switch_pkg::hdr_t       pkt_hdr_o,
    output switch_pkg::port_mask_t out_port_o,
    output logic                   empty_o
);

    // write beats read, a write while full overwrites
    always_ff @(posedge clk) begin
        if (reset_i) begin
            empty_o <= 1'b1;
        end else if (wr_i) begin
            empty_o <= 1'b0;
        end else if (rd_i) begin
            empty_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            pkt_hdr_o  <= pkt_hdr_i;
            out_port_o <= out_port_i;
        end
    end

    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (reset_i)
        empty_o |-> !rd_i
    );

endmodule

/* hdl/switch_core.sv */
`timescale 1ns/1ps

module switch_core #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                          clk,
    input  logic                          reset_i,
    // packet in
    input  logic                          sw_wr_i,
    input  switch_pkg::hdr_t              sw_pkt_hdr_i,
    // packet out
    input  logic                          sw_rd_i,
    output switch_pkg::hdr_t              sw_pkt_hdr_o,
    output switch_pkg::port_mask_t        sw_out_port_o,
    output logic                          sw_out_empty_o,
    // controller access to the tables
    input  logic                          ctrl_mem_ce_i,
    input  logic                          ctrl_mem_we_i,
    input  logic [switch_pkg::ADDR_W-1:0] ctrl_mem_addr_i,
    input  logic [switch_pkg::DATA_W-1:0] ctrl_mem_data_i,
    output logic [switch_pkg::DATA_W-1:0] ctrl_mem_data_o,
    output logic                          ctrl_mem_ready_o
);
    import switch_pkg::*;

    parse_entry_t           parse_tab [PARSE_SIZE];
    match_entry_t           match_tab [NUM_ENTRIES];
    action_t                action_tab [NUM_ENTRIES];
    action_t                miss_action;

    logic                   ps_valid;
    hdr_t                   ps_hdr;
    hdr_id_t                ps_hdr_id;
    logic [NUM_ENTRIES-1:0] mt_hits;
    hdr_id_t                mt_hdr_ids [NUM_ENTRIES];

    logic                   ex_wr;
    hdr_t                   ex_hdr;
    port_mask_t             ex_port;

    flow_table #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) flow_table0 (
        .clk(clk),
        .reset_i(reset_i),
        .ctrl_mem_ce_i(ctrl_mem_ce_i),
        .ctrl_mem_we_i(ctrl_mem_we_i),
        .ctrl_mem_addr_i(ctrl_mem_addr_i),
        .ctrl_mem_data_i(ctrl_mem_data_i),
        .ctrl_mem_data_o(ctrl_mem_data_o),
        .ctrl_mem_ready_o(ctrl_mem_ready_o),
        .parse_tab_o(parse_tab),
        .match_tab_o(match_tab),
        .action_tab_o(action_tab),
        .miss_action_o(miss_action)
    );

    // stage 1, parser and matcher side by side
    hdr_parser hdr_parser0 (
        .clk(clk),
        .reset_i(reset_i),
        .pkt_valid_i(sw_wr_i),
        .pkt_hdr_i(sw_pkt_hdr_i),
        .parse_tab_i(parse_tab),
        .ps_valid_o(ps_valid),
        .ps_hdr_o(ps_hdr),
        .ps_hdr_id_o(ps_hdr_id)
    );

    key_matcher #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) key_matcher0 (
        .clk(clk),
        .reset_i(reset_i),
        .pkt_valid_i(sw_wr_i),
        .pkt_hdr_i(sw_pkt_hdr_i),
        .match_tab_i(match_tab),
        .mt_hits_o(mt_hits),
        .mt_hdr_ids_o(mt_hdr_ids)
    );

    // stage 2
    action_executor #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) action_executor0 (
        .clk(clk),
        .reset_i(reset_i),
        .ps_valid_i(ps_valid),
        .ps_hdr_i(ps_hdr),
        .ps_hdr_id_i(ps_hdr_id),
        .mt_hits_i(mt_hits),
        .mt_hdr_ids_i(mt_hdr_ids),
        .action_tab_i(action_tab),
        .miss_action_i(miss_action),
        .ex_wr_o(ex_wr),
        .ex_hdr_o(ex_hdr),
        .ex_port_o(ex_port)
    );

    pkt_latch pkt_latch0 (
        .clk(clk),
        .reset_i(reset_i),
        .wr_i(ex_wr),
        .pkt_hdr_i(ex_hdr),
        .out_port_i(ex_port),
        .rd_i(sw_rd_i),
        .pkt_hdr_o(sw_pkt_hdr_o),
        .out_port_o(sw_out_port_o),
        .empty_o(sw_out_empty_o)
    );

endmodule

/* sim/tb_switch_core.sv */
`timescale 1ns/1ps

module tb_switch_core;
    import switch_pkg::*;

    localparam int NUM_ENTRIES = 8;
    localparam int PIDX_W      = $clog2(PARSE_SIZE);
    localparam int EIDX_W      = $clog2(NUM_ENTRIES);
    localparam int NUM_PKTS    = 16;
    // the tests take roughly 500 cycles
    localparam int MAX_CYCLES  = 2000;

    logic              clk;
    logic              reset_i;
    logic              sw_wr_i;
    hdr_t              sw_pkt_hdr_i;
    logic              sw_rd_i;
    hdr_t              sw_pkt_hdr_o;
    port_mask_t        sw_out_port_o;
    logic              sw_out_empty_o;
    logic              ctrl_mem_ce_i;
    logic              ctrl_mem_we_i;
    logic [ADDR_W-1:0] ctrl_mem_addr_i;
    logic [DATA_W-1:0] ctrl_mem_data_i;
    logic [DATA_W-1:0] ctrl_mem_data_o;
    logic              ctrl_mem_ready_o;

    // mirror of what has been written to the tables
    parse_entry_t ref_parse [PARSE_SIZE];
    match_entry_t ref_match [NUM_ENTRIES];
    action_t      ref_act [NUM_ENTRIES];
    action_t      ref_miss;

    integer seed = 71093;
    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    int cycle_count = 0;

    switch_core #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) i_switch_core (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, run stopped after %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    task automatic compare_hdr(input string name, input hdr_t got, input hdr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_port(input string name, input port_mask_t got, input port_mask_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_data(input string name, input logic [DATA_W-1:0] got,
                                input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    function automatic logic [ADDR_W-1:0] tab_addr(input logic [1:0] region, input int idx);
        return {region, (ADDR_W-2)'(idx)};
    endfunction

    function automatic parse_entry_t make_parse(input logic [7:0] tag, input hdr_id_t id);
        parse_entry_t p;
        p        = '0;
        p.valid  = 1'b1;
        p.tag    = tag;
        p.hdr_id = id;
        return p;
    endfunction

    function automatic match_entry_t make_match(input hdr_id_t id, input key_t key);
        match_entry_t m;
        m        = '0;
        m.valid  = 1'b1;
        m.hdr_id = id;
        m.key    = key;
        return m;
    endfunction

    function automatic action_t make_action(input op_e op, input port_mask_t port,
                                            input logic [3:0] idx, input logic [7:0] val);
        action_t a;
        a          = '0;
        a.op       = op;
        a.port     = port;
        a.byte_idx = idx;
        a.byte_val = val;
        return a;
    endfunction

    // random header with the tag and key bytes set
    function automatic hdr_t make_hdr(input logic [7:0] tag, input key_t key);
        hdr_t h;
        for (int w = 0; w < HDR_LEN / 4; w++) begin
            h[w*32 +: 32] = $random(seed);
        end
        h[TAG_OFF*8 +: 8] = tag;
        h[KEY_OFF*8 +: KEY_BYTES*8] = key;
        return h;
    endfunction

    // expected output of one packet, returns 0 when it is dropped
    function automatic logic model_pkt(input hdr_t h, output hdr_t exp_hdr,
                                       output port_mask_t exp_port);
        hdr_id_t cls;
        logic    found;
        action_t a;
        cls   = '0;
        found = 1'b0;
        for (int i = 0; i < PARSE_SIZE; i++) begin
            if (!found && ref_parse[i].valid && ref_parse[i].tag == h[TAG_OFF*8 +: 8]) begin
                cls   = ref_parse[i].hdr_id;
                found = 1'b1;
            end
        end
        a     = ref_miss;
        found = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!found && ref_match[i].valid && ref_match[i].hdr_id == cls &&
                ref_match[i].key == h[KEY_OFF*8 +: KEY_BYTES*8]) begin
                a     = ref_act[i];
                found = 1'b1;
            end
        end
        exp_hdr  = h;
        exp_port = a.port;
        if (a.op == OP_REWRITE) begin
            exp_hdr[int'(a.byte_idx)*8 +: 8] = a.byte_val;
        end
        return a.op != OP_DROP;
    endfunction

    // one controller cycle, ready and read data expected on the next edge
    task automatic table_access(input logic we, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] rdata);
        ctrl_mem_ce_i   = 1'b1;
        ctrl_mem_we_i   = we;
        ctrl_mem_addr_i = addr;
        ctrl_mem_data_i = wdata;
        @(negedge clk);
        ctrl_mem_ce_i = 1'b0;
        ctrl_mem_we_i = 1'b0;
        rdata = ctrl_mem_data_o;
        if (ctrl_mem_ready_o !== 1'b1) begin
            report_failure($sformatf("no ready one cycle after chip enable, address %h", addr));
        end
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused_rd;
        logic [ADDR_W-3:0] idx;
        table_access(1'b1, addr, data, unused_rd);
        idx = addr[ADDR_W-3:0];
        case (addr[ADDR_W-1 -: 2])
            REGION_PARSE: if (idx < (ADDR_W-2)'(PARSE_SIZE)) ref_parse[idx[PIDX_W-1:0]] = data;
            REGION_MATCH: if (idx < (ADDR_W-2)'(NUM_ENTRIES)) ref_match[idx[EIDX_W-1:0]] = data;
            REGION_ACTION: if (idx < (ADDR_W-2)'(NUM_ENTRIES)) ref_act[idx[EIDX_W-1:0]] = data;
            default: if (idx == '0) ref_miss = data;
        endcase
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        table_access(1'b0, addr, '0, data);
    endtask

    task automatic clear_tables();
        for (int i = 0; i < PARSE_SIZE; i++) begin
            write_word(tab_addr(REGION_PARSE, i), '0);
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            write_word(tab_addr(REGION_MATCH, i), '0);
            write_word(tab_addr(REGION_ACTION, i), '0);
        end
        write_word(tab_addr(REGION_MISS, 0), '0);
    endtask

    task automatic drain_output();
        if (!sw_out_empty_o) begin
            sw_rd_i = 1'b1;
            @(negedge clk);
            sw_rd_i = 1'b0;
            if (!sw_out_empty_o) begin
                report_failure("empty flag did not rise after a read");
            end
        end
    endtask

    // send one packet, wait for it and compare with the model
    task automatic check_packet(input hdr_t h);
        hdr_t       exp_hdr;
        port_mask_t exp_port;
        logic       fwd;
        int         edges;
        fwd          = model_pkt(h, exp_hdr, exp_port);
        sw_wr_i      = 1'b1;
        sw_pkt_hdr_i = h;
        @(negedge clk);
        sw_wr_i = 1'b0;
        edges   = 1;
        while (sw_out_empty_o && edges < 8) begin
            @(negedge clk);
            edges++;
        end
        if (!fwd) begin
            if (!sw_out_empty_o) begin
                report_failure("dropped packet reached the output");
            end
        end else if (sw_out_empty_o) begin
            report_failure("no packet at the output within 8 cycles");
        end else begin
            if (edges != 3) begin
                report_failure($sformatf("packet arrived after %0d edges instead of 3", edges));
            end
            compare_hdr("sw_pkt_hdr_o", sw_pkt_hdr_o, exp_hdr);
            compare_port("sw_out_port_o", sw_out_port_o, exp_port);
        end
        drain_output();
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic reset_and_readback();
        int                errs;
        logic [DATA_W-1:0] rd;
        errs = error_count;
        if (sw_out_empty_o !== 1'b1) begin
            report_failure("output not empty after reset");
        end
        if (ctrl_mem_ready_o !== 1'b0) begin
            report_failure("ready high after reset");
        end
        read_word(tab_addr(REGION_MISS, 0), rd);
        compare_data("ctrl_mem_data_o", rd, '0);
        write_word(tab_addr(REGION_PARSE, 3), 32'h8001_2A05);
        write_word(tab_addr(REGION_MATCH, 6), 32'h800A_C0DE);
        write_word(tab_addr(REGION_ACTION, 7), 32'h4000_0B3F);
        write_word(tab_addr(REGION_MISS, 0), 32'h8000_0800);
        write_word(tab_addr(REGION_MISS, 2), 32'hFFFF_FFFF);
        read_word(tab_addr(REGION_PARSE, 3), rd);
        compare_data("ctrl_mem_data_o", rd, 32'h8001_2A05);
        read_word(tab_addr(REGION_MATCH, 6), rd);
        compare_data("ctrl_mem_data_o", rd, 32'h800A_C0DE);
        read_word(tab_addr(REGION_ACTION, 7), rd);
        compare_data("ctrl_mem_data_o", rd, 32'h4000_0B3F);
        read_word(tab_addr(REGION_MISS, 0), rd);
        compare_data("ctrl_mem_data_o", rd, 32'h8000_0800);
        // indices past the end that alias onto written entries
        read_word(tab_addr(REGION_PARSE, PARSE_SIZE + 3), rd);
        compare_data("ctrl_mem_data_o", rd, '0);
        read_word(tab_addr(REGION_MATCH, NUM_ENTRIES + 6), rd);
        compare_data("ctrl_mem_data_o", rd, '0);
        read_word(tab_addr(REGION_ACTION, 63), rd);
        compare_data("ctrl_mem_data_o", rd, '0);
        read_word(tab_addr(REGION_MISS, 2), rd);
        compare_data("ctrl_mem_data_o", rd, '0);
        end_test("reset and readback", errs);
    endtask

    task automatic forward_on_hit();
        int errs;
        errs = error_count;
        clear_tables();
        write_word(tab_addr(REGION_PARSE, 0), make_parse(8'h45, 4'd1));
        write_word(tab_addr(REGION_MATCH, 2), make_match(4'd1, 16'h0800));
        write_word(tab_addr(REGION_ACTION, 2), make_action(OP_FORWARD, 4'b0100, 4'd0, 8'h00));
        check_packet(make_hdr(8'h45, 16'h0800));
        check_packet(make_hdr(8'h45, 16'h0800));
        end_test("forward on hit", errs);
    endtask

    task automatic rewrite_byte();
        int errs;
        errs = error_count;
        clear_tables();
        write_word(tab_addr(REGION_PARSE, 1), make_parse(8'h11, 4'd2));
        write_word(tab_addr(REGION_MATCH, 0), make_match(4'd2, 16'hBEEF));
        write_word(tab_addr(REGION_ACTION, 0), make_action(OP_REWRITE, 4'b0001, 4'd9, 8'hA5));
        check_packet(make_hdr(8'h11, 16'hBEEF));
        // rewrite the tag byte itself
        write_word(tab_addr(REGION_ACTION, 0), make_action(OP_REWRITE, 4'b1010, 4'd0, 8'h77));
        check_packet(make_hdr(8'h11, 16'hBEEF));
        end_test("rewrite", errs);
    endtask

    task automatic class_and_priority();
        int errs;
        errs = error_count;
        clear_tables();
        write_word(tab_addr(REGION_PARSE, 0), make_parse(8'h20, 4'd3));
        write_word(tab_addr(REGION_PARSE, 1), make_parse(8'h21, 4'd4));
        // same tag again at a higher index, class 3 must still win
        write_word(tab_addr(REGION_PARSE, 2), make_parse(8'h20, 4'd4));
        write_word(tab_addr(REGION_MATCH, 1), make_match(4'd4, 16'h1111));
        write_word(tab_addr(REGION_ACTION, 1), make_action(OP_FORWARD, 4'b0010, 4'd0, 8'h00));
        write_word(tab_addr(REGION_MATCH, 3), make_match(4'd3, 16'h1111));
        write_word(tab_addr(REGION_ACTION, 3), make_action(OP_FORWARD, 4'b1000, 4'd0, 8'h00));
        write_word(tab_addr(REGION_MATCH, 5), make_match(4'd3, 16'h2222));
        write_word(tab_addr(REGION_ACTION, 5), make_action(OP_FORWARD, 4'b0001, 4'd0, 8'h00));
        write_word(tab_addr(REGION_MATCH, 6), make_match(4'd3, 16'h2222));
        write_word(tab_addr(REGION_ACTION, 6), make_action(OP_REWRITE, 4'b0100, 4'd4, 8'hEE));
        check_packet(make_hdr(8'h20, 16'h1111));
        check_packet(make_hdr(8'h21, 16'h1111));
        check_packet(make_hdr(8'h20, 16'h2222));
        end_test("class and priority", errs);
    endtask

    task automatic miss_and_drop();
        int           errs;
        match_entry_t off;
        errs = error_count;
        clear_tables();
        write_word(tab_addr(REGION_MISS, 0), make_action(OP_REWRITE, 4'b0010, 4'd15, 8'h3C));
        write_word(tab_addr(REGION_PARSE, 0), make_parse(8'h30, 4'd5));
        write_word(tab_addr(REGION_MATCH, 0), make_match(4'd5, 16'h1234));
        write_word(tab_addr(REGION_ACTION, 0), make_action(OP_DROP, 4'b0001, 4'd0, 8'h00));
        off       = make_match(4'd5, 16'h5678);
        off.valid = 1'b0;
        write_word(tab_addr(REGION_MATCH, 1), off);
        write_word(tab_addr(REGION_ACTION, 1), make_action(OP_FORWARD, 4'b1000, 4'd0, 8'h00));
        check_packet(make_hdr(8'h31, 16'h1234));
        check_packet(make_hdr(8'h30, 16'h9999));
        check_packet(make_hdr(8'h30, 16'h5678));
        check_packet(make_hdr(8'h30, 16'h1234));
        write_word(tab_addr(REGION_MISS, 0), make_action(OP_DROP, 4'b0000, 4'd0, 8'h00));
        check_packet(make_hdr(8'h31, 16'h1234));
        end_test("miss and drop", errs);
    endtask

    task automatic back_to_back();
        int          errs;
        int          waited;
        logic [31:0] r;
        key_t        keys [4];
        hdr_t        pkts [NUM_PKTS];
        hdr_t        exp_hdrs [$];
        port_mask_t  exp_ports [$];
        hdr_t        eh;
        port_mask_t  ep;
        op_e         op;
        errs = error_count;
        clear_tables();
        for (int i = 0; i < 4; i++) begin
            r       = $random(seed);
            keys[i] = r[15:0];
            write_word(tab_addr(REGION_PARSE, i), make_parse(8'h40 + 8'(i), hdr_id_t'(i + 1)));
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            r  = $random(seed);
            op = (r[5:4] == 2'd3) ? OP_FORWARD : op_e'(r[5:4]);
            write_word(tab_addr(REGION_MATCH, i),
                       make_match({2'b00, r[1:0]} + 4'd1, keys[r[3:2]]));
            write_word(tab_addr(REGION_ACTION, i),
                       make_action(op, (r[11:8] == '0) ? 4'b0001 : r[11:8], r[15:12], r[23:16]));
        end
        write_word(tab_addr(REGION_MISS, 0), make_action(OP_FORWARD, 4'b1000, 4'd0, 8'h00));
        for (int k = 0; k < NUM_PKTS; k++) begin
            r       = $random(seed);
            pkts[k] = make_hdr(8'h40 + {5'b0, r[2:0]}, r[3] ? r[31:16] : keys[r[5:4]]);
            if (model_pkt(pkts[k], eh, ep)) begin
                exp_hdrs.push_back(eh);
                exp_ports.push_back(ep);
            end
        end
        fork
            begin
                for (int k = 0; k < NUM_PKTS; k++) begin
                    sw_wr_i      = 1'b1;
                    sw_pkt_hdr_i = pkts[k];
                    @(negedge clk);
                end
                sw_wr_i = 1'b0;
            end
            begin
                waited = 0;
                while (exp_hdrs.size() > 0 && waited < NUM_PKTS + 10) begin
                    sw_rd_i = !sw_out_empty_o;
                    if (!sw_out_empty_o) begin
                        eh = exp_hdrs.pop_front();
                        ep = exp_ports.pop_front();
                        compare_hdr("sw_pkt_hdr_o", sw_pkt_hdr_o, eh);
                        compare_port("sw_out_port_o", sw_out_port_o, ep);
                    end
                    @(negedge clk);
                    waited++;
                end
                sw_rd_i = 1'b0;
            end
        join
        if (exp_hdrs.size() > 0) begin
            report_failure($sformatf("%0d packets never reached the output", exp_hdrs.size()));
        end
        repeat (4) begin
            @(negedge clk);
            if (!sw_out_empty_o) begin
                report_failure("unexpected extra packet at the output");
                drain_output();
            end
        end
        end_test("back-to-back packets", errs);
    endtask

    initial begin
        reset_i         = 1'b1;
        sw_wr_i         = 1'b0;
        sw_pkt_hdr_i    = '0;
        sw_rd_i         = 1'b0;
        ctrl_mem_ce_i   = 1'b0;
        ctrl_mem_we_i   = 1'b0;
        ctrl_mem_addr_i = '0;
        ctrl_mem_data_i = '0;
        for (int i = 0; i < PARSE_SIZE; i++) begin
            ref_parse[i] = '0;
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ref_match[i] = '0;
            ref_act[i]   = '0;
        end
        ref_miss = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);

        reset_and_readback();
        forward_on_hit();
        rewrite_byte();
        class_and_priority();
        miss_and_drop();
        back_to_back();

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sim.f */
common/switch_pkg.sv
hdl/flow_table.sv
pipeline/hdr_parser.sv
pipeline/key_matcher.sv
pipeline/action_executor.sv
hdl/pkt_latch.sv
hdl/switch_core.sv
sim/tb_switch_core.sv

/* Makefile */
TOP = tb_switch_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
		--top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f sim.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir
